/* verilog.f */
+incdir+common
common/rrag_pkg.sv
hdl/arch_regs.sv
hdl/rrag_stage.sv
operand_fetch/operand_fetch.sv
operand_fetch/wb_arbiter.sv
hdl/rrag_top.sv
tb/rrag_properties.sv
tb/rrag_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rrag_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test passed
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/rrag_tb.sv */
`include "rrag_macros.svh"

module rrag_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_UOPS   = 80;
    localparam int          CLK_PERIOD = 8;
    localparam logic [31:0] SEED       = 32'd88928;
    localparam logic [31:0] MEM_KEY    = 32'h5ca1_ab1e;

    logic                     clk;
    logic                     rst_n;
    rrag_pkg::seg_init_t      seg_init;
    logic                     in_valid;
    rrag_pkg::uop_t           in_uop;
    logic                     in_ready;
    rrag_pkg::regwb_t         regwb;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic [`RRAG_ADDR_W-1:0]  wb_adr;
    logic                     wb_we;
    logic [`RRAG_DATA_W-1:0]  wb_dat_i;
    logic                     wb_ack;
    logic                     out_valid;
    logic                     out_ready;
    rrag_pkg::result_t        out_result;

    logic [`RRAG_DATA_W-1:0]  shadow_gpr [`RRAG_NUM_GPR];
    logic [15:0]              shadow_seg [`RRAG_NUM_SEG];
    logic [`RRAG_NUM_GPR-1:0] shadow_pend;
    logic [31:0]              drv_state;
    rrag_pkg::result_t        expq [$];
    int                       errors = 0;
    int                       received = 0;

    rrag_top rrag_top_inst (
        .clk(clk), .rst_n(rst_n), .seg_init(seg_init),
        .in_valid(in_valid), .in_uop(in_uop), .in_ready(in_ready), .regwb(regwb),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_we(wb_we),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_drv();
        drv_state = xorshift32(drv_state);
        return drv_state;
    endfunction

    function automatic rrag_pkg::uop_t random_uop(input int n);
        rrag_pkg::uop_t u;
        logic [31:0]    r;
        r           = next_drv();
        u.base_reg  = r[2:0];
        u.index_reg = r[5:3];
        u.str_reg   = r[8:6];
        u.seg1      = 3'(int'(r[13:9]) % `RRAG_NUM_SEG);
        u.seg2      = 3'(int'(r[17:14]) % `RRAG_NUM_SEG);
        u.scale     = r[19:18];
        u.use_base  = r[20];
        u.use_index = r[21];
        u.mem1_en   = r[22] | r[23];
        u.mem2_en   = r[24] | r[25];
        u.dest_en   = r[26];
        u.dest_reg  = r[29:27];
        u.disp      = next_drv();
        u.tag       = 8'(n);
        return u;
    endfunction

    // half of the writebacks go to a register that is waiting for one
    function automatic rrag_pkg::regwb_t random_writeback();
        rrag_pkg::regwb_t w;
        logic [31:0]      r;
        logic [2:0]       pick;
        r    = next_drv();
        pick = r[3:1];
        if (r[4] && shadow_pend != '0) begin
            while (!shadow_pend[pick]) begin
                pick = pick + 3'd1;
            end
        end
        w.en    = r[0];
        w.rnum  = pick;
        w.value = next_drv();
        return w;
    endfunction

    function automatic logic [`RRAG_NUM_GPR-1:0] address_regs(input rrag_pkg::uop_t u);
        logic [`RRAG_NUM_GPR-1:0] m;
        m = '0;
        if (u.mem1_en && u.use_base) begin
            m[u.base_reg] = 1'b1;
        end
        if (u.mem1_en && u.use_index) begin
            m[u.index_reg] = 1'b1;
        end
        if (u.mem2_en) begin
            m[u.str_reg] = 1'b1;
        end
        return m;
    endfunction

    // effective addresses from the shadow registers, data follows the memory rule
    function automatic rrag_pkg::result_t expected_result(input rrag_pkg::uop_t u);
        rrag_pkg::result_t r;
        logic [31:0]       a1;
        logic [31:0]       a2;
        a1 = u.disp + (32'(shadow_seg[u.seg1]) << `RRAG_SEG_SHIFT);
        if (u.use_base) begin
            a1 = a1 + shadow_gpr[u.base_reg];
        end
        if (u.use_index) begin
            a1 = a1 + shadow_gpr[u.index_reg] * (32'd1 << u.scale);
        end
        a2       = shadow_gpr[u.str_reg] + (32'(shadow_seg[u.seg2]) << `RRAG_SEG_SHIFT);
        r.tag    = u.tag;
        r.valid1 = u.mem1_en;
        r.valid2 = u.mem2_en;
        r.data1  = a1 ^ MEM_KEY;
        r.data2  = a2 ^ MEM_KEY;
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : stimulus
        rrag_pkg::uop_t   cur_uop;
        rrag_pkg::regwb_t cur_wb;
        logic             valid_drv;
        logic             acc_now;
        int               issued;
        drv_state = SEED;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_uop    = '0;
        regwb     = '0;
        for (int i = 0; i < `RRAG_NUM_SEG; i++) begin
            seg_init.base[i] = 16'(next_drv());
            shadow_seg[i]    = seg_init.base[i];
        end
        shadow_pend = '0;
        cur_uop     = '0;
        valid_drv   = 1'b0;
        acc_now     = 1'b0;
        issued      = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // the general registers have no reset, so load all of them first
        for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
            @(posedge clk);
            cur_wb = '{en: 1'b1, rnum: 3'(i), value: next_drv()};
            regwb <= cur_wb;
            shadow_gpr[i] = cur_wb.value;
        end
        while (issued < NUM_UOPS) begin
            @(posedge clk);
            // addresses use the register values from before this edge
            if (acc_now) begin
                check_value("pending address register at issue",
                            32'(address_regs(cur_uop) & shadow_pend), 32'd0);
                expq.push_back(expected_result(cur_uop));
                issued++;
            end
            if (cur_wb.en) begin
                shadow_gpr[cur_wb.rnum]  = cur_wb.value;
                shadow_pend[cur_wb.rnum] = 1'b0;
            end
            if (acc_now && cur_uop.dest_en) begin
                shadow_pend[cur_uop.dest_reg] = 1'b1;
            end
            cur_wb = random_writeback();
            regwb <= cur_wb;
            if (acc_now || !valid_drv) begin
                valid_drv = (issued < NUM_UOPS) && ((next_drv() & 32'h3) != 32'd0);
                if (valid_drv) begin
                    cur_uop = random_uop(issued);
                end
            end
            in_valid <= valid_drv;
            in_uop   <= cur_uop;
            @(negedge clk);
            acc_now = valid_drv && in_ready;
        end
        @(posedge clk);
        regwb <= '0;
        wait (received == NUM_UOPS);
        repeat (8) @(posedge clk);
        $display("%0d errors, %0d of %0d results checked, %0d expected results left",
                 errors, received, NUM_UOPS, expq.size());
        if (errors == 0 && expq.size() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // memory model acks after 0 to 3 wait cycles
    initial begin : memory
        logic [31:0] mem_state;
        logic [31:0] adr;
        int          delay;
        mem_state = SEED ^ 32'hffff_0000;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        forever begin
            @(negedge clk);
            if (wb_cyc && wb_stb) begin
                adr = wb_adr;
                check_value("wb_we on an operand read", 32'(wb_we), 32'd0);
                mem_state = xorshift32(mem_state);
                delay     = int'(mem_state[1:0]);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                wb_ack   <= 1'b1;
                wb_dat_i <= adr ^ MEM_KEY;
                @(posedge clk);
                wb_ack <= 1'b0;
            end
        end
    end

    initial begin : compare
        rrag_pkg::result_t exp_r;
        logic [31:0]       sink_state;
        sink_state = SEED ^ 32'h0000_ffff;
        out_ready  = 1'b0;
        forever begin
            @(posedge clk);
            sink_state = xorshift32(sink_state);
            out_ready <= (sink_state[1:0] != 2'b00);
            @(negedge clk);
            if (out_valid && out_ready) begin
                if (expq.size() == 0) begin
                    $display("a result with tag %h came out at %0t ns with nothing issued for it",
                             out_result.tag, $time);
                    errors++;
                end else begin
                    exp_r = expq.pop_front();
                    check_value("tag", 32'(out_result.tag), 32'(exp_r.tag));
                    check_value("valid1", 32'(out_result.valid1), 32'(exp_r.valid1));
                    check_value("valid2", 32'(out_result.valid2), 32'(exp_r.valid2));
                    if (exp_r.valid1) begin
                        check_value("data1", out_result.data1, exp_r.data1);
                    end
                    if (exp_r.valid2) begin
                        check_value("data2", out_result.data2, exp_r.data2);
                    end
                end
                received++;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_UOPS * 40) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived within %0d cycles",
                 received, NUM_UOPS, NUM_UOPS * 40);
        $display("Test failed");
        $finish;
    end

endmodule

/* tb/rrag_properties.sv */
module rrag_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              cyc,
    input logic              stb,
    input logic              ack,
    input rrag_pkg::wb_req_t bus_req,
    input logic              in_ready,
    input logic              out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // high from the second reset edge on, once the registers have been cleared
    logic reset_held;

    always_ff @(posedge clk) begin
        reset_held <= !rst_n;
    end

    // the master that holds the bus keeps it, and its request, until the ack
    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        cyc && !ack |=> cyc && $stable(bus_req))
        else $error("bus handed to another master before ack");

    stb_until_ack: assert property (@(posedge clk) disable iff (!rst_n) stb && !ack |=> stb)
        else $error("stb dropped before ack");

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) ack |-> stb)
        else $error("ack without stb");

    quiet_in_reset: assert property (@(posedge clk)
        reset_held && !rst_n |-> !in_ready && !out_valid && !cyc)
        else $error("handshake or bus active during reset");

endmodule

bind wb_arbiter rrag_properties arb_props (
    .clk(clk), .rst_n(rst_n), .cyc(cyc_o), .stb(stb_o), .ack(ack_i),
    .bus_req(req_o), .in_ready(1'b0), .out_valid(1'b0)
);

bind rrag_top rrag_properties top_props (
    .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack),
    .bus_req(bus_req), .in_ready(in_ready), .out_valid(out_valid)
);

/* hdl/rrag_top.sv */
`include "rrag_macros.svh"

module rrag_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rrag_pkg::seg_init_t      seg_init,
    input  logic                     in_valid,
    input  rrag_pkg::uop_t           in_uop,
    output logic                     in_ready,
    input  rrag_pkg::regwb_t         regwb,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [`RRAG_ADDR_W-1:0]  wb_adr,
    output logic                     wb_we,
    input  logic [`RRAG_DATA_W-1:0]  wb_dat_i,
    input  logic                     wb_ack,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rrag_pkg::result_t        out_result
);

    logic [2:0]                rd_base;
    logic [2:0]                rd_index;
    logic [2:0]                rd_str;
    logic [2:0]                rd_seg1;
    logic [2:0]                rd_seg2;
    logic [`RRAG_DATA_W-1:0]   base_val;
    logic [`RRAG_DATA_W-1:0]   index_val;
    logic [`RRAG_DATA_W-1:0]   str_val;
    logic [15:0]               seg1_val;
    logic [15:0]               seg2_val;
    logic [`RRAG_NUM_GPR-1:0]  pending;
    logic                      mark_en;
    logic [2:0]                mark_reg;
    rrag_pkg::agen_t           agen1;
    rrag_pkg::agen_t           agen2;
    logic                      agen1_valid;
    logic                      agen2_valid;
    logic                      agen1_ready;
    logic                      agen2_ready;
    logic [1:0]                m_cyc;
    logic [1:0]                m_stb;
    logic [1:0]                m_ack;
    rrag_pkg::wb_req_t         m_req [2];
    logic [`RRAG_DATA_W-1:0]   m_dat;
    rrag_pkg::wb_req_t         bus_req;
    logic                      f1_done;
    logic                      f2_done;
    logic [`RRAG_DATA_W-1:0]   f1_data;
    logic [`RRAG_DATA_W-1:0]   f2_data;
    rrag_pkg::agen_t           f1_rec;
    rrag_pkg::agen_t           f2_rec;
    logic                      take;

    arch_regs u_regs (
        .clk(clk), .rst_n(rst_n), .seg_init(seg_init),
        .rd_base(rd_base), .rd_index(rd_index), .rd_str(rd_str),
        .rd_seg1(rd_seg1), .rd_seg2(rd_seg2),
        .mark_en(mark_en), .mark_reg(mark_reg), .regwb(regwb),
        .base_val(base_val), .index_val(index_val), .str_val(str_val),
        .seg1_val(seg1_val), .seg2_val(seg2_val), .pending(pending)
    );

    rrag_stage u_stage (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_uop(in_uop),
        .in_ready(in_ready),
        .rd_base(rd_base), .rd_index(rd_index), .rd_str(rd_str),
        .rd_seg1(rd_seg1), .rd_seg2(rd_seg2),
        .base_val(base_val), .index_val(index_val), .str_val(str_val),
        .seg1_val(seg1_val), .seg2_val(seg2_val), .pending(pending),
        .mark_en(mark_en), .mark_reg(mark_reg),
        .agen1(agen1), .agen1_valid(agen1_valid), .agen1_ready(agen1_ready),
        .agen2(agen2), .agen2_valid(agen2_valid), .agen2_ready(agen2_ready)
    );

    operand_fetch u_fetch1 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(agen1_valid), .req(agen1), .req_ready(agen1_ready),
        .cyc(m_cyc[0]), .stb(m_stb[0]), .wbreq(m_req[0]),
        .ack(m_ack[0]), .dat_i(m_dat),
        .data_valid(f1_done), .data(f1_data), .rec(f1_rec), .take(take)
    );

    operand_fetch u_fetch2 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(agen2_valid), .req(agen2), .req_ready(agen2_ready),
        .cyc(m_cyc[1]), .stb(m_stb[1]), .wbreq(m_req[1]),
        .ack(m_ack[1]), .dat_i(m_dat),
        .data_valid(f2_done), .data(f2_data), .rec(f2_rec), .take(take)
    );

    wb_arbiter #(
        .req_type(rrag_pkg::wb_req_t)
    ) u_arb (
        .clk(clk), .rst_n(rst_n),
        .m_cyc(m_cyc), .m_stb(m_stb), .m_req(m_req),
        .m_ack(m_ack), .m_dat(m_dat),
        .cyc_o(wb_cyc), .stb_o(wb_stb), .req_o(bus_req),
        .ack_i(wb_ack), .dat_i(wb_dat_i)
    );

    assign wb_adr = bus_req.adr;
    assign wb_we  = bus_req.we;

    // both fetchers finish every micro-op, used or not, so they stay paired
    assign out_valid = f1_done && f2_done;
    assign take      = out_valid && out_ready;

    assign out_result.tag    = f1_rec.tag;
    assign out_result.data1  = f1_data;
    assign out_result.data2  = f2_data;
    assign out_result.valid1 = f1_rec.en;
    assign out_result.valid2 = f2_rec.en;

endmodule

/* operand_fetch/wb_arbiter.sv */
`include "rrag_macros.svh"

module wb_arbiter #(
    parameter type req_type = logic [31:0]
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [1:0]               m_cyc,
    input  logic [1:0]               m_stb,
    input  req_type                  m_req [2],
    output logic [1:0]               m_ack,
    output logic [`RRAG_DATA_W-1:0]  m_dat,
    output logic                     cyc_o,
    output logic                     stb_o,
    output req_type                  req_o,
    input  logic                     ack_i,
    input  logic [`RRAG_DATA_W-1:0]  dat_i
);

    logic prio;
    logic owner;
    logic locked;
    logic cur;

    // a locked cycle keeps its owner, otherwise the priority master goes first
    always_comb begin
        if (locked) begin
            cur = owner;
        end else if (m_cyc[prio]) begin
            cur = prio;
        end else begin
            cur = ~prio;
        end
    end

    assign cyc_o    = m_cyc[cur];
    assign stb_o    = m_stb[cur];
    assign req_o    = m_req[cur];
    assign m_ack[0] = ack_i && cyc_o && !cur;
    assign m_ack[1] = ack_i && cyc_o && cur;
    assign m_dat    = dat_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio   <= 1'b0;
            owner  <= 1'b0;
            locked <= 1'b0;
        end else if (cyc_o && ack_i) begin
            locked <= 1'b0;
            prio   <= ~cur;
        end else if (cyc_o) begin
            locked <= 1'b1;
            owner  <= cur;
        end
    end

endmodule

/* operand_fetch/operand_fetch.sv */
`include "rrag_macros.svh"

module operand_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  rrag_pkg::agen_t          req,
    output logic                     req_ready,
    output logic                     cyc,
    output logic                     stb,
    output rrag_pkg::wb_req_t        wbreq,
    input  logic                     ack,
    input  logic [`RRAG_DATA_W-1:0]  dat_i,
    output logic                     data_valid,
    output logic [`RRAG_DATA_W-1:0]  data,
    output rrag_pkg::agen_t          rec,
    input  logic                     take
);

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_hold
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= req.en ? st_bus : st_hold;
                    end
                end
                st_bus: begin
                    if (ack) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (take) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // an unused operand finishes with a zero word and no bus cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            rec  <= req;
            data <= '0;
        end else if (state == st_bus && ack) begin
            data <= dat_i;
        end
    end

    assign req_ready  = (state == st_idle);
    assign cyc        = (state == st_bus);
    assign stb        = (state == st_bus);
    assign wbreq.adr  = rec.addr;
    assign wbreq.we   = 1'b0;

    // data_valid means the fetch is finished, rec.en tells if it was a real read
    assign data_valid = (state == st_hold);

endmodule

/* hdl/rrag_stage.sv */
`include "rrag_macros.svh"

module rrag_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  rrag_pkg::uop_t            in_uop,
    output logic                      in_ready,
    output logic [2:0]                rd_base,
    output logic [2:0]                rd_index,
    output logic [2:0]                rd_str,
    output logic [2:0]                rd_seg1,
    output logic [2:0]                rd_seg2,
    input  logic [`RRAG_DATA_W-1:0]   base_val,
    input  logic [`RRAG_DATA_W-1:0]   index_val,
    input  logic [`RRAG_DATA_W-1:0]   str_val,
    input  logic [15:0]               seg1_val,
    input  logic [15:0]               seg2_val,
    input  logic [`RRAG_NUM_GPR-1:0]  pending,
    output logic                      mark_en,
    output logic [2:0]                mark_reg,
    output rrag_pkg::agen_t           agen1,
    output logic                      agen1_valid,
    input  logic                      agen1_ready,
    output rrag_pkg::agen_t           agen2,
    output logic                      agen2_valid,
    input  logic                      agen2_ready
);

    logic                    running;
    logic                    dep_stall;
    logic                    slots_free;
    logic                    accept;
    logic [`RRAG_ADDR_W-1:0] base_term;
    logic [`RRAG_ADDR_W-1:0] index_term;
    logic [`RRAG_ADDR_W-1:0] seg1_base;
    logic [`RRAG_ADDR_W-1:0] seg2_base;
    logic [`RRAG_ADDR_W-1:0] addr1;
    logic [`RRAG_ADDR_W-1:0] addr2;

    assign rd_base  = in_uop.base_reg;
    assign rd_index = in_uop.index_reg;
    assign rd_str   = in_uop.str_reg;
    assign rd_seg1  = in_uop.seg1;
    assign rd_seg2  = in_uop.seg2;

    // only registers that feed an enabled address can hold the micro-op back
    assign dep_stall = (in_uop.mem1_en &&
                        ((in_uop.use_base && pending[in_uop.base_reg]) ||
                         (in_uop.use_index && pending[in_uop.index_reg]))) ||
                       (in_uop.mem2_en && pending[in_uop.str_reg]);

    assign slots_free = (!agen1_valid || agen1_ready) && (!agen2_valid || agen2_ready);
    assign in_ready   = running && !dep_stall && slots_free;
    assign accept     = in_valid && in_ready;
    assign mark_en    = accept && in_uop.dest_en;
    assign mark_reg   = in_uop.dest_reg;

    assign base_term  = in_uop.use_base ? base_val : '0;
    assign index_term = in_uop.use_index ? (index_val << in_uop.scale) : '0;
    assign seg1_base  = `RRAG_ADDR_W'(seg1_val) << `RRAG_SEG_SHIFT;
    assign seg2_base  = `RRAG_ADDR_W'(seg2_val) << `RRAG_SEG_SHIFT;
    assign addr1      = base_term + index_term + in_uop.disp + seg1_base;
    assign addr2      = str_val + seg2_base;

    // running holds issue off for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running     <= 1'b0;
            agen1_valid <= 1'b0;
            agen2_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (accept) begin
                agen1_valid <= 1'b1;
                agen2_valid <= 1'b1;
            end else begin
                if (agen1_ready) begin
                    agen1_valid <= 1'b0;
                end
                if (agen2_ready) begin
                    agen2_valid <= 1'b0;
                end
            end
        end
    end

    // both slots get a record so the fetchers stay in step with issue order
    always_ff @(posedge clk) begin
        if (accept) begin
            agen1 <= '{en: in_uop.mem1_en, addr: addr1, tag: in_uop.tag};
            agen2 <= '{en: in_uop.mem2_en, addr: addr2, tag: in_uop.tag};
        end
    end

endmodule

/* hdl/arch_regs.sv */
`include "rrag_macros.svh"

module arch_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rrag_pkg::seg_init_t       seg_init,
    input  logic [2:0]                rd_base,
    input  logic [2:0]                rd_index,
    input  logic [2:0]                rd_str,
    input  logic [2:0]                rd_seg1,
    input  logic [2:0]                rd_seg2,
    input  logic                      mark_en,
    input  logic [2:0]                mark_reg,
    input  rrag_pkg::regwb_t          regwb,
    output logic [`RRAG_DATA_W-1:0]   base_val,
    output logic [`RRAG_DATA_W-1:0]   index_val,
    output logic [`RRAG_DATA_W-1:0]   str_val,
    output logic [15:0]               seg1_val,
    output logic [15:0]               seg2_val,
    output logic [`RRAG_NUM_GPR-1:0]  pending
);

    logic [`RRAG_DATA_W-1:0] gpr [`RRAG_NUM_GPR];
    logic [15:0]             seg [`RRAG_NUM_SEG];

    always_ff @(posedge clk) begin
        if (regwb.en) begin
            gpr[regwb.rnum] <= regwb.value;
        end
    end

    // segment bases are only loaded from the init vector during reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_SEG; i++) begin
                seg[i] <= seg_init.base[i];
            end
        end
    end

    // writeback clears first so a mark on the same register takes over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (regwb.en) begin
                pending[regwb.rnum] <= 1'b0;
            end
            if (mark_en) begin
                pending[mark_reg] <= 1'b1;
            end
        end
    end

    assign base_val  = gpr[rd_base];
    assign index_val = gpr[rd_index];
    assign str_val   = gpr[rd_str];

    // segment numbers 6 and 7 do not exist and read as a zero base
    always_comb begin
        seg1_val = '0;
        seg2_val = '0;
        if (32'(rd_seg1) < `RRAG_NUM_SEG) begin
            seg1_val = seg[rd_seg1];
        end
        if (32'(rd_seg2) < `RRAG_NUM_SEG) begin
            seg2_val = seg[rd_seg2];
        end
    end

endmodule

/* common/rrag_pkg.sv */
`include "rrag_macros.svh"

package rrag_pkg;

    // decoded micro-op as it leaves the decoder
    typedef struct packed {
        logic [2:0]              base_reg;
        logic [2:0]              index_reg;
        logic [2:0]              str_reg;
        logic [2:0]              seg1;
        logic [2:0]              seg2;
        logic [1:0]              scale;
        logic                    use_base;
        logic                    use_index;
        logic                    mem1_en;
        logic                    mem2_en;
        logic                    dest_en;
        logic [2:0]              dest_reg;
        logic [`RRAG_ADDR_W-1:0] disp;
        logic [7:0]              tag;
    } uop_t;

    // one generated address, en is low when the operand is unused
    typedef struct packed {
        logic                    en;
        logic [`RRAG_ADDR_W-1:0] addr;
        logic [7:0]              tag;
    } agen_t;

    typedef struct packed {
        logic [`RRAG_ADDR_W-1:0] adr;
        logic                    we;
    } wb_req_t;

    typedef struct packed {
        logic [7:0]              tag;
        logic [`RRAG_DATA_W-1:0] data1;
        logic [`RRAG_DATA_W-1:0] data2;
        logic                    valid1;
        logic                    valid2;
    } result_t;

    typedef struct packed {
        logic                    en;
        logic [2:0]              rnum;
        logic [`RRAG_DATA_W-1:0] value;
    } regwb_t;

    typedef struct packed {
        logic [`RRAG_NUM_SEG-1:0][15:0] base;
    } seg_init_t;

endpackage

/* common/rrag_macros.svh */
`ifndef RRAG_MACROS_SVH
`define RRAG_MACROS_SVH

// architectural register counts
`define RRAG_NUM_GPR 8
`define RRAG_NUM_SEG 6

`define RRAG_ADDR_W 32
`define RRAG_DATA_W 32

// a segment base sits above the 16-bit offset
`define RRAG_SEG_SHIFT 16

`endif
